/* hdl/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath widths
`define XLEN    32
`define REG_AW  5   // x0..x31
`define CSR_AW  12

// Major opcodes
`define OP_OP      7'b0110011  // R-type ALU
`define OP_OP_IMM  7'b0010011  // I-type ALU
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_SYSTEM  7'b1110011  // Zicsr only

// ALU funct3
`define F3_ADD   3'b000  // ADD, SUB, ADDI, also JALR
`define F3_SLL   3'b001
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101  // SRL, SRA and imm forms
`define F3_OR    3'b110
`define F3_AND   3'b111

// Zicsr funct3
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010
`define F3_CSRRC   3'b011
`define F3_CSRRWI  3'b101
`define F3_CSRRSI  3'b110
`define F3_CSRRCI  3'b111

// Implemented CSRs
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341

`define RESET_PC  32'h0000_0000

`endif

/* hdl/exec_pkg.sv */
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  ////////////////////
  // Scalar types
  ////////////////////

  typedef logic [`XLEN-1:0]   word_t;      // Data word / PC
  typedef logic [`REG_AW-1:0] reg_addr_t;  // GPR index
  typedef logic [`CSR_AW-1:0] csr_addr_t;  // CSR index

  // ALU select
  // 000 add, 001 sub, 010 and, 011 or
  // 100 xor, 101 sll, 110 srl, 111 sra
  typedef logic [2:0] alu_op_t;

  // CSR select, same as funct3
  // 001/010/011 reg forms, 101/110/111 imm forms, 000 none
  typedef logic [2:0] csr_op_t;

  ////////////////////
  // Stage records
  ////////////////////

  // Decode to execute
  typedef struct packed {
    logic      valid;     // Legal instr in flight
    word_t     pc;        // Instr address
    word_t     a;         // rs1 or PC
    word_t     b;         // rs2, imm or zimm
    alu_op_t   alu_op;
    logic      lui;
    logic      auipc;
    logic      jal;
    logic      jalr;
    logic      compare;   // SLTU / SLTIU
    csr_op_t   csr_op;    // Nonzero for Zicsr
    csr_addr_t csr_addr;
    reg_addr_t rd;
  } id_ex_t;

  // Retired result
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage : exec_pkg

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module alu (
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::word_t   pres_adr,  // PC of instr in execute
  input  exec_pkg::alu_op_t alusel,
  input  logic              lui,
  input  logic              jal,
  input  logic              jalr,
  input  logic              auipc,
  input  logic              compare,
  input  exec_pkg::csr_op_t csrsel,
  input  exec_pkg::word_t   csr_in,    // Current CSR value
  output exec_pkg::word_t   res,
  output exec_pkg::word_t   csr_res,   // New CSR value
  output logic              comp_res
);

  exec_pkg::word_t s;
  exec_pkg::word_t link;

  // Unsigned compare, high if a < b
  assign comp_res = (a < b);

  // Return address, no compressed instrs
  assign link = pres_adr + 32'd4;

  ////////////////////
  // Arithmetic / logic
  ////////////////////

  always_comb begin
    case (alusel)
      3'b000:  s = a + b;
      3'b001:  s = a - b;
      3'b010:  s = a & b;
      3'b011:  s = a | b;
      3'b100:  s = a ^ b;
      3'b101:  s = a << b[4:0];
      3'b110:  s = a >> b[4:0];
      3'b111:  s = $signed(a) >>> b[4:0];  // Sign fill
      default: s = '0;
    endcase
  end

  ////////////////////
  // CSR update
  ////////////////////

  always_comb begin
    case (csrsel)
      `F3_CSRRW:  csr_res = a;
      `F3_CSRRS:  csr_res = csr_in | a;
      `F3_CSRRC:  csr_res = csr_in & ~a;   // Clear bits set in rs1
      `F3_CSRRWI: csr_res = b;             // b holds zimm
      `F3_CSRRSI: csr_res = csr_in | b;
      `F3_CSRRCI: csr_res = csr_in & ~b;
      default:    csr_res = '0;
    endcase
  end

  // Result mux, priority order
  assign res = lui         ? b :                                     // LUI
               auipc       ? (b + pres_adr) :                        // AUIPC
               (jal| jalr) ? link :                                  // JAL / JALR
               compare     ? {{(`XLEN-1){1'b0}}, comp_res} :         // SLTU / SLTIU
               s;

endmodule : alu

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  exec_pkg::reg_addr_t rs1_addr,
  input  exec_pkg::reg_addr_t rs2_addr,
  output exec_pkg::word_t     rs1_data,
  output exec_pkg::word_t     rs2_data,
  input  logic                we,
  input  exec_pkg::reg_addr_t wr_addr,
  input  exec_pkg::word_t     wr_data
);

  localparam int unsigned NREG = 1 << `REG_AW;  // 32 GPRs

  // x1..x31 only
  exec_pkg::word_t regs [1:NREG-1];

  // Write port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wr_addr != '0)) begin  // x0 writes ignored
      regs[wr_addr] <= wr_data;
    end
  end

  // Read ports, old data on same-cycle write
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule : reg_file

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module instr_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                instr_valid,  // One-cycle strobe
  input  exec_pkg::word_t     instr,
  input  exec_pkg::word_t     instr_pc,
  output exec_pkg::reg_addr_t rs1_addr,
  output exec_pkg::reg_addr_t rs2_addr,
  input  exec_pkg::word_t     rs1_data,
  input  exec_pkg::word_t     rs2_data,
  input  exec_pkg::word_t     fwd_data,     // Result of instr in execute
  output exec_pkg::id_ex_t    id_ex
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  exec_pkg::reg_addr_t rd;
  exec_pkg::word_t     imm_i;
  exec_pkg::word_t     imm_u;
  exec_pkg::word_t     imm_j;
  exec_pkg::word_t     zimm;
  logic                fwd_rs1;
  logic                fwd_rs2;
  exec_pkg::word_t     op1;
  exec_pkg::word_t     op2;
  logic                alu_f3_ok;
  logic                legal;
  exec_pkg::id_ex_t    id_ex_nxt;

  // funct3 to ALU select, alt picks SUB / SRA
  function automatic exec_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      `F3_ADD: alu_sel = alt ? 3'b001 : 3'b000;
      `F3_SLL: alu_sel = 3'b101;
      `F3_XOR: alu_sel = 3'b100;
      `F3_SR:  alu_sel = alt ? 3'b111 : 3'b110;
      `F3_OR:  alu_sel = 3'b011;
      `F3_AND: alu_sel = 3'b010;
      default: alu_sel = 3'b000;  // SLTU goes through comparator
    endcase
  endfunction

  ////////////////////
  // Field split
  ////////////////////

  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign zimm  = {27'b0, instr[19:15]};  // CSR imm forms

  ////////////////////
  // Forwarding
  ////////////////////

  // Only the instr in execute can be missing from the RF
  assign fwd_rs1 = id_ex.valid && (id_ex.rd != '0) && (id_ex.rd == rs1_addr);
  assign fwd_rs2 = id_ex.valid && (id_ex.rd != '0) && (id_ex.rd == rs2_addr);

  assign op1 = fwd_rs1 ? fwd_data : rs1_data;
  assign op2 = fwd_rs2 ? fwd_data : rs2_data;

  assign alu_f3_ok = (funct3 != 3'b010);  // Signed SLT/SLTI not supported

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    id_ex_nxt          = '0;
    id_ex_nxt.pc       = instr_pc;
    id_ex_nxt.a        = op1;
    id_ex_nxt.b        = op2;
    id_ex_nxt.rd       = rd;
    id_ex_nxt.csr_addr = instr[31:20];
    legal              = 1'b0;
    case (opcode)
      `OP_OP: begin
        legal = alu_f3_ok && ((funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && (funct3 == `F3_ADD || funct3 == `F3_SR)));
        id_ex_nxt.alu_op  = alu_sel(funct3, funct7[5]);
        id_ex_nxt.compare = (funct3 == `F3_SLTU);
      end
      `OP_OP_IMM: begin
        // Shamt forms carry funct7 in imm[11:5]
        if (funct3 == `F3_SLL)
          legal = (funct7 == 7'b0000000);
        else if (funct3 == `F3_SR)
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        else
          legal = alu_f3_ok;
        id_ex_nxt.alu_op  = alu_sel(funct3, (funct3 == `F3_SR) && instr[30]);
        id_ex_nxt.compare = (funct3 == `F3_SLTU);
        id_ex_nxt.b       = imm_i;
      end
      `OP_LUI: begin
        legal         = 1'b1;
        id_ex_nxt.lui = 1'b1;
        id_ex_nxt.b   = imm_u;
      end
      `OP_AUIPC: begin
        legal           = 1'b1;
        id_ex_nxt.auipc = 1'b1;
        id_ex_nxt.b     = imm_u;  // PC added in ALU
      end
      `OP_JAL: begin
        legal         = 1'b1;
        id_ex_nxt.jal = 1'b1;
        id_ex_nxt.a   = instr_pc;  // Link only
        id_ex_nxt.b   = imm_j;
      end
      `OP_JALR: begin
        legal          = (funct3 == `F3_ADD);
        id_ex_nxt.jalr = 1'b1;
        id_ex_nxt.a    = instr_pc;
        id_ex_nxt.b    = imm_i;
      end
      `OP_SYSTEM: begin
        case (funct3)
          `F3_CSRRW, `F3_CSRRS, `F3_CSRRC,
          `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI: legal = 1'b1;
          default:                            legal = 1'b0;  // ECALL etc.
        endcase
        id_ex_nxt.csr_op = funct3;
        id_ex_nxt.b      = zimm;
      end
      default: legal = 1'b0;
    endcase
    id_ex_nxt.valid = instr_valid && legal;  // Unknown instr is dropped here
  end

  ////////////////////
  // ID/EX register
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex    <= '0;
      id_ex.pc <= `RESET_PC;
    end else begin
      id_ex <= id_ex_nxt;
    end
  end

endmodule : instr_decode

`default_nettype wire

/* hdl/writeback.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module writeback (
  input  logic                clk,
  input  logic                arst_n,
  input  exec_pkg::id_ex_t    id_ex,
  input  exec_pkg::word_t     res,
  input  exec_pkg::word_t     csr_res,
  output exec_pkg::word_t     csr_in,    // CSR read for ALU
  output exec_pkg::word_t     fwd_data,  // Back to decode
  output logic                rf_we,
  output exec_pkg::reg_addr_t rf_addr,
  output exec_pkg::word_t     rf_data,
  output exec_pkg::wb_t       wb
);

  exec_pkg::word_t mtvec;
  exec_pkg::word_t mscratch;
  exec_pkg::word_t mepc;
  exec_pkg::word_t rd_val;
  logic            is_csr;
  logic            csr_known;
  logic            csr_we;

  assign is_csr = (id_ex.csr_op != '0);

  ////////////////////
  // CSR file
  ////////////////////

  // Read side, unknown address reads 0
  always_comb begin
    csr_known = 1'b1;
    case (id_ex.csr_addr)
      `CSR_MTVEC:    csr_in = mtvec;
      `CSR_MSCRATCH: csr_in = mscratch;
      `CSR_MEPC:     csr_in = mepc;
      default: begin
        csr_in    = '0;
        csr_known = 1'b0;
      end
    endcase
  end

  assign csr_we = id_ex.valid && is_csr && csr_known;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
    end else if (csr_we) begin
      case (id_ex.csr_addr)
        `CSR_MTVEC:    mtvec    <= csr_res;
        `CSR_MSCRATCH: mscratch <= csr_res;
        `CSR_MEPC:     mepc     <= csr_res;
        default:       mepc     <= mepc;
      endcase
    end
  end

  ////////////////////
  // Retire
  ////////////////////

  assign rd_val   = is_csr ? csr_in : res;  // Zicsr returns old CSR value
  assign fwd_data = rd_val;

  // RF written on the same edge as wb capture
  assign rf_we   = id_ex.valid && (id_ex.rd != '0);
  assign rf_addr = id_ex.rd;
  assign rf_data = rd_val;

  // EX/WB register, zero between pulses
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else if (id_ex.valid) begin
      wb.valid <= 1'b1;
      wb.rd    <= id_ex.rd;
      wb.data  <= rd_val;
    end else begin
      wb <= '0;
    end
  end

endmodule : writeback

`default_nettype wire

/* hdl/exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_valid,
  input  exec_pkg::word_t instr,
  input  exec_pkg::word_t instr_pc,
  output exec_pkg::wb_t   wb
);

  // Decode <-> RF
  exec_pkg::reg_addr_t rs1_addr;
  exec_pkg::reg_addr_t rs2_addr;
  exec_pkg::word_t     rs1_data;
  exec_pkg::word_t     rs2_data;

  // Execute
  exec_pkg::id_ex_t    id_ex;
  exec_pkg::word_t     res;
  exec_pkg::word_t     csr_res;
  exec_pkg::word_t     csr_in;
  exec_pkg::word_t     fwd_data;

  // RF write
  logic                rf_we;
  exec_pkg::reg_addr_t rf_addr;
  exec_pkg::word_t     rf_data;

  instr_decode i_instr_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .fwd_data    (fwd_data),
    .id_ex       (id_ex)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .wr_addr  (rf_addr),
    .wr_data  (rf_data)
  );

  alu i_alu (
    .a        (id_ex.a),
    .b        (id_ex.b),
    .pres_adr (id_ex.pc),
    .alusel   (id_ex.alu_op),
    .lui      (id_ex.lui),
    .jal      (id_ex.jal),
    .jalr     (id_ex.jalr),
    .auipc    (id_ex.auipc),
    .compare  (id_ex.compare),
    .csrsel   (id_ex.csr_op),
    .csr_in   (csr_in),
    .res      (res),
    .csr_res  (csr_res),
    .comp_res ()              // Already folded into res
  );

  writeback i_writeback (
    .clk      (clk),
    .arst_n   (arst_n),
    .id_ex    (id_ex),
    .res      (res),
    .csr_res  (csr_res),
    .csr_in   (csr_in),
    .fwd_data (fwd_data),
    .rf_we    (rf_we),
    .rf_addr  (rf_addr),
    .rf_data  (rf_data),
    .wb       (wb)
  );

endmodule : exec_top

`default_nettype wire

/* bench/exec_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module exec_checker (
  input logic            clk,
  input logic            arst_n,
  input logic            instr_valid,
  input exec_pkg::word_t instr,
  input exec_pkg::word_t id_ex_a,  // Operand a in execute
  input exec_pkg::wb_t   wb
);

  logic [6:0] opcode;
  logic       always_legal;  // Opcodes with no illegal encodings
  logic       reads_rs1;     // a comes from rs1

  assign opcode       = instr[6:0];
  assign always_legal = (opcode == `OP_LUI) || (opcode == `OP_AUIPC) || (opcode == `OP_JAL);
  assign reads_rs1    = (opcode == `OP_OP) || (opcode == `OP_OP_IMM);

  ////////////////////
  // Reset
  ////////////////////

  a_wb_idle_in_reset : assert property (@(posedge clk) !arst_n |-> !wb.valid)
    else $error("wb.valid high while reset is asserted");

  ////////////////////
  // Pipeline timing
  ////////////////////

  // Legal strobe retires two edges later
  a_wb_follows_strobe : assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid && always_legal |-> ##2 wb.valid)
    else $error("Legal instr_valid not followed by wb.valid two cycles later");

  // Pulse is two edges behind its strobe
  a_wb_has_strobe : assert property (@(posedge clk) disable iff (!arst_n)
    wb.valid |-> $past(instr_valid, 2))
    else $error("wb.valid not preceded by instr_valid two cycles earlier");

  // x0 reads zero even right after a retire to x0
  a_x0_reads_zero : assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid && reads_rs1 && (instr[19:15] == '0) |=> (id_ex_a == '0))
    else $error("Nonzero operand read from x0");

endmodule : exec_checker

bind exec_top exec_checker i_exec_checker (
  .clk         (clk),
  .arst_n      (arst_n),
  .instr_valid (instr_valid),
  .instr       (instr),
  .id_ex_a     (id_ex.a),
  .wb          (wb)
);

`default_nettype wire

/* bench/exec_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module exec_tb;

  typedef struct packed {
    logic [31:0]   due;  // Cycle count at the expected pulse
    exec_pkg::wb_t wb;
  } exp_t;

  logic            clk;
  logic            arst_n;
  logic            instr_valid;
  exec_pkg::word_t instr;
  exec_pkg::word_t instr_pc;
  exec_pkg::wb_t   wb;

  logic [15:0]     lfsr;
  logic [31:0]     cyc;          // Rising edges since reset
  int              errors;
  int              timeouts;
  exp_t            exp_q [$];
  exec_pkg::word_t gpr [32];     // Model register file
  exec_pkg::word_t csr_m [4];    // mtvec, mscratch, mepc, unmapped (stays 0)

  exec_top i_exec_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .wb          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) cyc <= '0;
    else         cyc <= cyc + 1;
  end

  // 16-bit Galois LFSR, x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  function automatic exec_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic exec_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
    enc_r = {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [11:0] csr_of(input int c);
    case (c)
      0:       csr_of = `CSR_MTVEC;
      1:       csr_of = `CSR_MSCRATCH;
      2:       csr_of = `CSR_MEPC;
      default: csr_of = 12'h7C0;  // Not implemented
    endcase
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // RV32I subset per the ISA spec, updates model state
  function automatic exec_pkg::wb_t model_exec(input exec_pkg::word_t ins,
                                               input exec_pkg::word_t pc);
    exec_pkg::wb_t   r;
    exec_pkg::word_t v1;
    exec_pkg::word_t v2;
    exec_pkg::word_t src;
    exec_pkg::word_t nw;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            ok;
    int              ci;
    f3   = ins[14:12];
    f7   = ins[31:25];
    v1   = gpr[ins[19:15]];
    v2   = gpr[ins[24:20]];
    r    = '0;
    r.rd = ins[11:7];
    ok   = 1'b1;
    case (ins[6:0])
      `OP_OP, `OP_OP_IMM: begin
        if (ins[6:0] == `OP_OP_IMM) begin
          v2 = {{20{ins[31]}}, ins[31:20]};
          if (f3 == 3'b001)      ok = (f7 == 7'h00);  // SLLI
          else if (f3 == 3'b101) ok = (f7 == 7'h00) || (f7 == 7'h20);
        end else begin
          ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
        end
        ok = ok && (f3 != 3'b010);  // No signed SLT
        case (f3)
          3'b000: r.data = (ins[5] && f7[5]) ? v1 - v2 : v1 + v2;  // SUB only in R form
          3'b001: r.data = v1 << v2[4:0];
          3'b011: r.data = (v1 < v2) ? 32'd1 : 32'd0;
          3'b100: r.data = v1 ^ v2;
          3'b101: begin
            if (f7[5]) r.data = $signed(v1) >>> v2[4:0];
            else       r.data = v1 >> v2[4:0];
          end
          3'b110: r.data = v1 | v2;
          3'b111: r.data = v1 & v2;
          default: r.data = '0;
        endcase
      end
      `OP_LUI:   r.data = {ins[31:12], 12'h000};
      `OP_AUIPC: r.data = pc + {ins[31:12], 12'h000};
      `OP_JAL:   r.data = pc + 32'd4;
      `OP_JALR: begin
        ok     = (f3 == 3'b000);
        r.data = pc + 32'd4;
      end
      `OP_SYSTEM: begin
        ok = (f3 != 3'b000) && (f3 != 3'b100);
        ci = 3;
        for (int k = 0; k < 3; k++) begin
          if (ins[31:20] == csr_of(k)) ci = k;
        end
        src = f3[2] ? {27'b0, ins[19:15]} : v1;  // zimm or rs1
        case (f3[1:0])
          2'b01:   nw = src;
          2'b10:   nw = csr_m[ci] | src;
          2'b11:   nw = csr_m[ci] & ~src;
          default: nw = csr_m[ci];
        endcase
        r.data = csr_m[ci];  // Old value to rd
        if (ok && (ci != 3)) csr_m[ci] = nw;
      end
      default: ok = 1'b0;
    endcase
    r.valid = ok;
    if (ok && (r.rd != 5'd0)) gpr[r.rd] = r.data;
    model_exec = r;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic issue(input exec_pkg::word_t ins, input exec_pkg::word_t pc);
    exp_t e;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = ins;
    instr_pc    = pc;
    e.due       = cyc + 2;  // Sampled at next edge, retired on the one after
    e.wb        = model_exec(ins, pc);
    if (e.wb.valid) exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid = 1'b0;
      instr       = '0;
      instr_pc    = '0;
    end
  endtask

  // Random OP / OP_IMM on x0..x7 so operands often depend on the last result
  task automatic gen_alu(output exec_pkg::word_t ins);
    logic [31:0] sel;
    logic [31:0] f3;
    logic [31:0] rd;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] imm;
    take_bits(2, sel);
    take_bits(3, f3);
    take_bits(3, rd);
    take_bits(3, r1);
    take_bits(3, r2);
    take_bits(12, imm);
    if (f3[2:0] == 3'b010) f3 = `F3_SLTU;
    if (sel[0]) begin
      if (f3[2:0] == `F3_SLL)     imm[11:5] = 7'h00;
      else if (f3[2:0] == `F3_SR) imm[11:5] = {1'b0, sel[1], 5'b0};  // SRLI / SRAI
      ins = enc_i(imm[11:0], r1[4:0], f3[2:0], rd[4:0], `OP_OP_IMM);
    end else begin
      ins = enc_r({1'b0, sel[1] && ((f3[2:0] == `F3_ADD) || (f3[2:0] == `F3_SR)), 5'b0},
                  r2[4:0], r1[4:0], f3[2:0], rd[4:0], `OP_OP);
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  always @(negedge clk) begin
    exp_t e;
    if (arst_n) begin
      if ((exp_q.size() > 0) && (exp_q[0].due == cyc)) begin
        e = exp_q.pop_front();
        if (wb.valid !== 1'b1) begin
          errors++;
          $display("ERR %0t wb.valid exp 1 got %b", $time, wb.valid);
        end
        if (wb.rd !== e.wb.rd) begin
          errors++;
          $display("ERR %0t wb.rd exp %0d got %0d", $time, e.wb.rd, wb.rd);
        end
        if (wb.data !== e.wb.data) begin
          errors++;
          $display("ERR %0t wb.data exp %h got %h", $time, e.wb.data, wb.data);
        end
      end else if (wb !== '0) begin  // Idle cycles, dropped instrs too
        errors++;
        $display("ERR %0t wb exp %h got %h", $time, {$bits(wb){1'b0}}, wb);
      end
    end
  end

  initial begin
    exec_pkg::word_t ins;
    exec_pkg::word_t pc;
    logic [31:0]     sel;
    logic [31:0]     imm;
    logic [31:0]     rd;
    logic [31:0]     v;
    int              wait_cnt;
    arst_n      = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    instr_pc    = '0;
    lfsr        = 16'd5434;
    errors      = 0;
    timeouts    = 0;
    for (int i = 0; i < 32; i++) gpr[i] = '0;
    for (int i = 0; i < 4; i++) csr_m[i] = '0;
    #1 arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle(4);  // wb must stay zero

    repeat (300) begin
      gen_alu(ins);
      issue(ins, '0);
    end
    idle(3);

    // U and J types, random word-aligned PCs
    repeat (60) begin
      take_bits(2, sel);
      take_bits(32, pc);
      take_bits(20, imm);
      take_bits(3, rd);
      pc[1:0] = 2'b00;
      case (sel[1:0])
        2'd0:    issue({imm[19:0], rd[4:0], `OP_LUI}, pc);
        2'd1:    issue({imm[19:0], rd[4:0], `OP_AUIPC}, pc);
        2'd2:    issue({imm[19:0], rd[4:0], `OP_JAL}, pc);
        default: issue(enc_i(imm[11:0], 5'd3, `F3_ADD, rd[4:0], `OP_JALR), pc);
      endcase
    end
    idle(2);

    // Every Zicsr op on each CSR, then a read back
    for (int c = 0; c < 4; c++) begin
      for (int f = 1; f < 8; f++) begin
        if (f != 4) begin
          take_bits(5, v);
          if (f < 4) v[4:3] = 2'b00;  // rs1 in x0..x7
          issue(enc_i(csr_of(c), v[4:0], f[2:0], 5'd5, `OP_SYSTEM), '0);
          issue(enc_i(csr_of(c), 5'd0, `F3_CSRRS, 5'd6, `OP_SYSTEM), '0);
        end
      end
    end
    idle(2);

    // Dropped instrs must not write or forward, x0 stays zero
    issue(enc_i(12'd7, 5'd0, `F3_ADD, 5'd1, `OP_OP_IMM), '0);
    issue(enc_i(12'd9, 5'd1, `F3_ADD, 5'd1, 7'b0000011), '0);       // Load
    issue(enc_r(7'h00, 5'd1, 5'd1, `F3_ADD, 5'd2, `OP_OP), '0);
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, `OP_OP), '0);      // SLT
    issue(enc_r(7'h01, 5'd2, 5'd1, `F3_ADD, 5'd3, `OP_OP), '0);     // MUL
    issue(enc_i(12'h000, 5'd0, 3'b000, 5'd0, `OP_SYSTEM), '0);      // ECALL
    issue(enc_i(12'd5, 5'd1, 3'b001, 5'd3, `OP_JALR), '0);          // Bad funct3
    issue(enc_i(12'd123, 5'd1, `F3_ADD, 5'd0, `OP_OP_IMM), '0);     // To x0
    issue(enc_r(7'h00, 5'd0, 5'd0, `F3_OR, 5'd4, `OP_OP), '0);
    issue(enc_r(7'h00, 5'd1, 5'd3, `F3_ADD, 5'd4, `OP_OP), '0);
    idle(2);

    wait_cnt = 0;
    while ((exp_q.size() > 0) && (wait_cnt < 20)) begin
      @(negedge clk);
      wait_cnt++;
    end
    @(negedge clk);
    if (exp_q.size() > 0) begin
      timeouts++;
      $display("Timeout: %0d expected wb pulses never arrived", exp_q.size());
    end
    $display("Done: %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : exec_tb

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/writeback.sv
hdl/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv
